// File: verilog.f
logic/quad_ctrl_pkg.sv
logic/job_handshake.sv
logic/pfb_reader.sv
logic/exec_scheduler.sv
logic/quad_sequencer.sv
logic/quad_bram_ctrl.sv
dv/quad_bram_ctrl_assertions.sv
dv/quad_bram_ctrl_tb.sv

// File: Bender.yml
package:
  name: quad_bram_ctrl

sources:
  # Package first, then the blocks, then the top level
  - logic/quad_ctrl_pkg.sv
  - logic/job_handshake.sv
  - logic/pfb_reader.sv
  - logic/exec_scheduler.sv
  - logic/quad_sequencer.sv
  - logic/quad_bram_ctrl.sv

  - target: test
    files:
      - dv/quad_bram_ctrl_assertions.sv
      - dv/quad_bram_ctrl_tb.sv

// File: dv/quad_bram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl_tb import quad_ctrl_pkg::*; ();

    ////////////////////////////////////////////////////////////
    // Job table
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [DIM_W-1:0] num_cols;
        logic [DIM_W-1:0] num_rows;
        logic [3:0]       fetch_dly;
        logic [3:0]       ack_dly;
    } job_entry_t;

    localparam int NUM_JOBS = 4;

    // num_cols, num_rows (last indices), fetch ack delay, completion ack delay
    localparam job_entry_t JOB_TABLE [NUM_JOBS] = '{
        '{9'd3, 9'd3, 4'd0, 4'd0},
        '{9'd5, 9'd6, 4'd1, 4'd2},
        '{9'd2, 9'd8, 4'd2, 4'd1},
        '{9'd7, 9'd4, 4'd0, 4'd3}
    };

    // Gray values of the row slot counter 0, 1, 2, 3
    localparam logic [1:0] GRAY_ORDER [4] = '{2'd0, 2'd1, 2'd3, 2'd2};

    localparam int          WAIT_LIMIT  = 2000;
    localparam int          EV_REQUEST  = 0;
    localparam int          EV_ACCEPT   = 1;
    localparam int          EV_COMPLETE = 2;
    localparam logic [31:0] SEED        = 32'hac16_e537;

    logic                  clk;
    logic                  rst;
    logic                  job_start;
    job_cfg_t              job_cfg;
    logic                  job_accept;
    fetch_rsp_t            fetch_rsp;
    fetch_if_t             fetch;
    logic                  job_complete;
    logic                  job_complete_ack;
    logic                  pfb_rden;
    logic [DIM_W-1:0]      wr_addr;
    logic                  seq_rden;
    logic [SEQ_ADDR_W-1:0] seq_rd_addr;
    logic [NUM_CE-1:0]     ce_execute;
    logic [1:0]            gray_code;

    // Monitor state
    logic [31:0]                 rng;
    int                          cur_cols = 1;
    int                          accept_count = 0;
    int                          request_count = 0;
    int                          rden_count = 0;
    int                          seq_count = 0;
    logic [1:0]                  gray_log [$];
    logic [SEQ_READ_LATENCY-1:0] rden_hist = '0;
    logic                        req_prev = 1'b0;
    logic                        ack_prev = 1'b0;
    logic                        complete_prev = 1'b0;
    logic                        cack_prev = 1'b0;
    logic [1:0]                  gray_prev = 2'd0;
    logic                        busy_exp = 1'b0;

    quad_bram_ctrl i_quad_bram_ctrl (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .job_cfg          (job_cfg),
        .job_accept       (job_accept),
        .fetch_rsp        (fetch_rsp),
        .fetch            (fetch),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .pfb_rden         (pfb_rden),
        .wr_addr          (wr_addr),
        .seq_rden         (seq_rden),
        .seq_rd_addr      (seq_rd_addr),
        .ce_execute       (ce_execute),
        .gray_code        (gray_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                    $time, name, actual, expected));
        end
    endtask

    function automatic logic event_seen(input int which);
        case (which)
            EV_REQUEST: return fetch.request;
            EV_ACCEPT:  return job_accept;
            default:    return job_complete;
        endcase
    endfunction

    // Polls on falling edges, where outputs are settled
    task automatic wait_event(input int which, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!event_seen(which)) begin
            if (cycles == WAIT_LIMIT) begin
                stop_on_error({"timeout while waiting for ", what});
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Fetcher model that acks and then completes one full input row
    task automatic serve_fetch(input int ack_dly, input int cols);
        int extra;
        wait_event(EV_REQUEST, "a fetch request");
        rng = lcg_step(rng);
        extra = int'(rng[31:30]);
        repeat (ack_dly + extra) @(posedge clk);
        @(posedge clk);
        fetch_rsp.ack <= 1'b1;
        @(posedge clk);
        fetch_rsp.ack <= 1'b0;
        rng = lcg_step(rng);
        repeat (int'(rng[31:29])) @(posedge clk);
        @(posedge clk);
        fetch_rsp <= '{ack: 1'b0, complete: 1'b1, full_count: DIM_W'(cols)};
        @(posedge clk);
        fetch_rsp.complete <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (job_accept) begin
                accept_count++;
            end
            if (fetch.request && !req_prev) begin
                request_count++;
            end
            if (req_prev && !fetch.request) begin
                check_value("fetch_rsp.ack before request drop", ack_prev, 1);
            end
            // Fetcher busy from its ack until its complete
            check_value("fetch.in_progress", fetch.in_progress, busy_exp);
            if (fetch_rsp.complete) begin
                busy_exp = 1'b0;
            end else if (fetch_rsp.ack) begin
                busy_exp = 1'b1;
            end
            if (pfb_rden) begin
                check_value("wr_addr", wr_addr, rden_count % cur_cols);
                rden_count++;
            end
            if (seq_rden) begin
                check_value("seq_rd_addr", seq_rd_addr, seq_count % SEQ_STEPS);
                seq_count++;
            end
            // Bit 0 trails seq_rden by the sequence BRAM latency
            check_value("ce_execute[0]", ce_execute[0], rden_hist[SEQ_READ_LATENCY-1]);
            rden_hist = {rden_hist[SEQ_READ_LATENCY-2:0], seq_rden};
            if (gray_code != gray_prev) begin
                gray_log.push_back(gray_code);
            end
            if (complete_prev && !job_complete) begin
                check_value("job_complete_ack before complete drop", cack_prev, 1);
            end
            if (i_quad_bram_ctrl.i_assertions.fail_count != 0) begin
                stop_on_error("a concurrent assertion on the DUT failed");
            end
            req_prev      = fetch.request;
            ack_prev      = fetch_rsp.ack;
            complete_prev = job_complete;
            cack_prev     = job_complete_ack;
            gray_prev     = gray_code;
        end
    end

    ////////////////////////////////////////////////////////////
    // Job sequence
    ////////////////////////////////////////////////////////////

    task automatic run_job(input job_entry_t job);
        int rows;
        int cols;
        int refills;
        int gray_changes;
        rows    = int'(job.num_rows) + 1;
        cols    = int'(job.num_cols) + 1;
        refills = rows - PRIME_ROWS;
        // One more change when DONE returns a nonzero slot to 0
        gray_changes  = refills + ((refills % 4 != 0) ? 1 : 0);
        cur_cols      = cols;
        accept_count  = 0;
        request_count = 0;
        rden_count    = 0;
        seq_count     = 0;
        gray_log.delete();

        @(posedge clk);
        job_cfg   <= '{num_cols: job.num_cols, num_rows: job.num_rows};
        job_start <= 1'b1;
        wait_event(EV_ACCEPT, "job_accept");
        @(posedge clk);
        job_start <= 1'b0;
        // A start while busy must be ignored
        repeat (2) @(posedge clk);
        job_start <= 1'b1;
        @(posedge clk);
        job_start <= 1'b0;

        for (int f = 0; f < rows; f++) begin
            serve_fetch(int'(job.fetch_dly), cols);
        end
        wait_event(EV_COMPLETE, "job_complete");

        check_value("job_accept pulses", accept_count, 1);
        check_value("fetch requests", request_count, rows);
        check_value("pfb_rden pulses", rden_count, rows * cols);
        check_value("seq_rden cycles", seq_count, SEQ_STEPS * cols * (rows - 3));
        check_value("gray_code at completion", gray_code, 0);
        check_value("gray_code changes", gray_log.size(), gray_changes);
        for (int k = 0; k < refills; k++) begin
            check_value("gray_code step", gray_log[k], GRAY_ORDER[(k + 1) % 4]);
        end

        repeat (int'(job.ack_dly)) @(posedge clk);
        @(posedge clk);
        job_complete_ack <= 1'b1;
        @(posedge clk);
        job_complete_ack <= 1'b0;
    endtask

    initial begin
        rst              <= 1'b1;
        job_start        <= 1'b0;
        job_cfg          <= '0;
        fetch_rsp        <= '0;
        job_complete_ack <= 1'b0;
        rng = SEED;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Control outputs and FSM state straight out of reset
        @(negedge clk);
        check_value("job_accept after reset", job_accept, 0);
        check_value("fetch.request after reset", fetch.request, 0);
        check_value("job_complete after reset", job_complete, 0);
        check_value("pfb_rden after reset", pfb_rden, 0);
        check_value("seq_rden after reset", seq_rden, 0);
        check_value("ce_execute after reset", ce_execute, 0);
        check_value("gray_code after reset", gray_code, 0);
        check_value("state after reset", i_quad_bram_ctrl.state, IDLE);

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(JOB_TABLE[j]);
        end
        // Let the CE chain empty out
        repeat (20) @(posedge clk);

        if (i_quad_bram_ctrl.i_assertions.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_on_error("concurrent assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: dv/quad_bram_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl_assertions import quad_ctrl_pkg::*; (
    input logic              clk,
    input logic              rst,
    input fetch_if_t         fetch,
    input fetch_rsp_t        fetch_rsp,
    input logic              job_complete,
    input logic              job_complete_ack,
    input logic [NUM_CE-1:0] ce_execute
);

    // Failed assertions so far, polled by the testbench
    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Fetch handshake
    ////////////////////////////////////////////////////////////

    req_idle_while_busy: assert property (
        @(posedge clk) disable iff (rst) fetch.in_progress |-> !fetch.request
    ) else begin
        fail_count++;
        $error("fetch request raised while a fetch is in progress");
    end

    // Request holds until the fetcher acks it
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (rst) fetch.request && !fetch_rsp.ack |=> fetch.request
    ) else begin
        fail_count++;
        $error("fetch request dropped without an ack");
    end

    ////////////////////////////////////////////////////////////
    // Completion and CE chain
    ////////////////////////////////////////////////////////////

    complete_held_until_ack: assert property (
        @(posedge clk) disable iff (rst) job_complete && !job_complete_ack |=> job_complete
    ) else begin
        fail_count++;
        $error("job_complete dropped without an ack");
    end

    for (genvar k = 0; k < NUM_CE - 1; k++) begin : g_chain
        ce_shift: assert property (
            @(posedge clk) disable iff (rst) ce_execute[k+1] == $past(ce_execute[k])
        ) else begin
            fail_count++;
            $error("ce_execute[%0d] does not follow ce_execute[%0d]", k + 1, k);
        end
    end

endmodule

bind quad_bram_ctrl quad_bram_ctrl_assertions i_assertions (
    .clk              (clk),
    .rst              (rst),
    .fetch            (fetch),
    .fetch_rsp        (fetch_rsp),
    .job_complete     (job_complete),
    .job_complete_ack (job_complete_ack),
    .ce_execute       (ce_execute)
);

`default_nettype wire

// File: logic/quad_bram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl import quad_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  job_start,
    input  job_cfg_t              job_cfg,
    output logic                  job_accept,
    input  fetch_rsp_t            fetch_rsp,
    output fetch_if_t             fetch,
    output logic                  job_complete,
    input  logic                  job_complete_ack,
    output logic                  pfb_rden,
    output logic [DIM_W-1:0]      wr_addr,
    output logic                  seq_rden,
    output logic [SEQ_ADDR_W-1:0] seq_rd_addr,
    output logic [NUM_CE-1:0]     ce_execute,
    output logic [1:0]            gray_code
);

    ////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////

    job_cfg_t         cfg;
    ctrl_state_t      state;
    logic             fetch_go;
    logic             fetch_done;
    logic             done_go;
    logic             complete_acked;
    logic             drain;
    logic             run;
    logic             row_loaded;
    logic             row_done;
    logic [DIM_W-1:0] input_row;
    logic [DIM_W-1:0] output_row;

    job_handshake i_job_handshake (
        .clk              (clk),
        .rst              (rst),
        .fetch_go         (fetch_go),
        .done_go          (done_go),
        .fetch_rsp        (fetch_rsp),
        .job_complete_ack (job_complete_ack),
        .fetch            (fetch),
        .fetch_done       (fetch_done),
        .job_complete     (job_complete),
        .complete_acked   (complete_acked)
    );

    pfb_reader i_pfb_reader (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .load       (fetch_done),
        .full_count (fetch_rsp.full_count),
        .drain      (drain),
        .pfb_rden   (pfb_rden),
        .wr_addr    (wr_addr),
        .input_row  (input_row),
        .row_loaded (row_loaded)
    );

    exec_scheduler i_exec_scheduler (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .run         (run),
        .seq_rden    (seq_rden),
        .seq_rd_addr (seq_rd_addr),
        .ce_execute  (ce_execute),
        .row_done    (row_done),
        .output_row  (output_row)
    );

    quad_sequencer i_quad_sequencer (
        .clk            (clk),
        .rst            (rst),
        .job_start      (job_start),
        .job_cfg        (job_cfg),
        .job_accept     (job_accept),
        .cfg            (cfg),
        .input_row      (input_row),
        .row_loaded     (row_loaded),
        .fetch_done     (fetch_done),
        .row_done       (row_done),
        .output_row     (output_row),
        .complete_acked (complete_acked),
        .fetch_go       (fetch_go),
        .drain          (drain),
        .run            (run),
        .done_go        (done_go),
        .gray_code      (gray_code),
        .state          (state)
    );

endmodule

`default_nettype wire

// File: logic/quad_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module quad_sequencer import quad_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             job_start,
    input  job_cfg_t         job_cfg,
    output logic             job_accept,
    output job_cfg_t         cfg,
    input  logic [DIM_W-1:0] input_row,
    input  logic             row_loaded,
    input  logic             fetch_done,
    input  logic             row_done,
    input  logic [DIM_W-1:0] output_row,
    input  logic             complete_acked,
    output logic             fetch_go,
    output logic             drain,
    output logic             run,
    output logic             done_go,
    output logic [1:0]       gray_code,
    output ctrl_state_t      state
);

    ctrl_state_t ret_state;
    logic        row_pending;
    logic [1:0]  slot;
    logic        primed;
    logic        last_out_row;

    // A four row map wraps the row index back to 0 when primed
    assign primed       = (input_row == DIM_W'(PRIME_ROWS)) || (input_row == '0);
    assign last_out_row = (output_row == cfg.num_rows - DIM_W'(3));

    assign fetch_go  = (state == WAIT_FETCH);
    assign run       = (state == ACTIVE);
    assign done_go   = (state == DONE);
    assign drain     = row_pending;
    assign gray_code = {slot[1], slot[1] ^ slot[0]};

    always_ff @(posedge clk) begin
        if (state == IDLE && job_start) begin
            cfg <= job_cfg;
        end
    end

    ////////////////////////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            ret_state   <= PRIME;
            row_pending <= 1'b0;
            slot        <= '0;
            job_accept  <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            if (row_loaded) begin
                row_pending <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= PRIME;
                    end
                end
                PRIME: begin
                    // Fetch and drain rows until the window is full
                    if (row_loaded) begin
                        ret_state <= PRIME;
                        state     <= primed ? ACTIVE : WAIT_FETCH;
                    end else if (!row_pending) begin
                        ret_state <= PRIME;
                        state     <= WAIT_FETCH;
                    end
                end
                WAIT_FETCH: begin
                    if (fetch_done) begin
                        row_pending <= 1'b1;
                        state       <= ret_state;
                    end
                end
                ACTIVE: begin
                    if (row_done) begin
                        if (last_out_row) begin
                            slot  <= '0;
                            state <= DONE;
                        end else begin
                            state <= FIN_ROW;
                        end
                    end
                end
                FIN_ROW: begin
                    // Rotate slot, then refill one row before the next output row
                    if (row_loaded) begin
                        state <= ACTIVE;
                    end else if (!row_pending) begin
                        slot      <= slot + 1'b1;
                        ret_state <= FIN_ROW;
                        state     <= WAIT_FETCH;
                    end
                end
                DONE: begin
                    if (complete_acked) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module exec_scheduler import quad_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  job_cfg_t              cfg,
    input  logic                  run,
    output logic                  seq_rden,
    output logic [SEQ_ADDR_W-1:0] seq_rd_addr,
    output logic [NUM_CE-1:0]     ce_execute,
    output logic                  row_done,
    output logic [DIM_W-1:0]      output_row
);

    logic [SEQ_ADDR_W-1:0]       step_cnt;
    logic [DIM_W-1:0]            col_cnt;
    logic                        armed;
    logic                        issue;
    logic                        last_step;
    logic                        last_col;
    logic                        last_row;
    logic [SEQ_READ_LATENCY-2:0] rden_dly;

    assign issue     = run && armed;
    assign last_step = (step_cnt == SEQ_ADDR_W'(SEQ_STEPS - 1));
    assign last_col  = (col_cnt == cfg.num_cols);
    assign last_row  = (output_row == cfg.num_rows - DIM_W'(3));

    ////////////////////////////////////////////////////////////
    // Sequence reads
    ////////////////////////////////////////////////////////////

    // Disarmed after the last read of a row until run drops
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rden    <= 1'b0;
            seq_rd_addr <= '0;
            step_cnt    <= '0;
            col_cnt     <= '0;
            armed       <= 1'b1;
            row_done    <= 1'b0;
        end else begin
            seq_rden <= issue;
            row_done <= 1'b0;
            if (!run) begin
                armed <= 1'b1;
            end
            if (issue) begin
                seq_rd_addr <= step_cnt;
                step_cnt    <= last_step ? '0 : step_cnt + 1'b1;
                if (last_step) begin
                    col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                    if (last_col) begin
                        armed    <= 1'b0;
                        row_done <= 1'b1;
                    end
                end
            end
        end
    end

    // Index of the row in progress, valid during row_done
    always_ff @(posedge clk) begin
        if (rst) begin
            output_row <= '0;
        end else if (row_done) begin
            output_row <= last_row ? '0 : output_row + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // CE execute chain
    ////////////////////////////////////////////////////////////

    // Two delay stages plus ce_execute[0] cover the BRAM read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rden_dly   <= '0;
            ce_execute <= '0;
        end else begin
            rden_dly   <= {rden_dly[SEQ_READ_LATENCY-3:0], seq_rden};
            ce_execute <= {ce_execute[NUM_CE-2:0], rden_dly[SEQ_READ_LATENCY-2]};
        end
    end

endmodule

`default_nettype wire

// File: logic/pfb_reader.sv
`timescale 1ns/1ps
`default_nettype none

module pfb_reader import quad_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  job_cfg_t         cfg,
    input  logic             load,
    input  logic [DIM_W-1:0] full_count,
    input  logic             drain,
    output logic             pfb_rden,
    output logic [DIM_W-1:0] wr_addr,
    output logic [DIM_W-1:0] input_row,
    output logic             row_loaded
);

    logic [DIM_W-1:0] pfb_count;
    logic [DIM_W-1:0] count_next;
    logic [DIM_W-1:0] input_col;
    logic             issue;
    logic             last_entry;

    ////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (load) begin
            count_next = full_count;
        end else if (pfb_rden) begin
            count_next = pfb_count - 1'b1;
        end else begin
            count_next = pfb_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else begin
            pfb_count <= count_next;
        end
    end

    // Strobe only while entries remain after the current one
    assign issue      = drain && !load && (count_next != '0);
    assign last_entry = pfb_rden && (pfb_count == DIM_W'(1));

    ////////////////////////////////////////////////////////////
    // Read strobe, write address, row tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_rden  <= 1'b0;
            wr_addr   <= '0;
            input_col <= '0;
        end else begin
            pfb_rden <= issue;
            if (issue) begin
                wr_addr   <= input_col;
                input_col <= (input_col == cfg.num_cols) ? '0 : input_col + 1'b1;
            end
        end
    end

    // Row index wraps after the last input row of the map
    always_ff @(posedge clk) begin
        if (rst) begin
            input_row  <= '0;
            row_loaded <= 1'b0;
        end else begin
            row_loaded <= last_entry;
            if (last_entry) begin
                input_row <= (input_row == cfg.num_rows) ? '0 : input_row + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/job_handshake.sv
`timescale 1ns/1ps
`default_nettype none

module job_handshake import quad_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_go,
    input  logic       done_go,
    input  fetch_rsp_t fetch_rsp,
    input  logic       job_complete_ack,
    output fetch_if_t  fetch,
    output logic       fetch_done,
    output logic       job_complete,
    output logic       complete_acked
);

    logic fetch_req;
    logic fetch_acked;
    logic fetch_busy;
    logic cmpl_acked;

    assign fetch = '{request: fetch_req, in_progress: fetch_busy};

    ////////////////////////////////////////////////////////////
    // Row fetch request
    ////////////////////////////////////////////////////////////

    // One request per WAIT_FETCH visit, dropped the cycle after ack
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_req   <= 1'b0;
            fetch_acked <= 1'b0;
        end else begin
            if (fetch_go && !fetch_busy) begin
                if (fetch_rsp.ack) begin
                    fetch_req   <= 1'b0;
                    fetch_acked <= 1'b1;
                end else if (!fetch_acked) begin
                    fetch_req <= 1'b1;
                end
            end else begin
                fetch_req <= 1'b0;
            end
            if (fetch_rsp.complete) begin
                fetch_acked <= 1'b0;
            end
        end
    end

    // Fetcher busy between ack and complete
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_busy <= 1'b0;
        end else begin
            if (fetch_rsp.ack && fetch_req) begin
                fetch_busy <= 1'b1;
            end
            if (fetch_rsp.complete) begin
                fetch_busy <= 1'b0;
            end
        end
    end

    assign fetch_done = fetch_rsp.complete && fetch_busy;

    ////////////////////////////////////////////////////////////
    // Job completion
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            job_complete <= 1'b0;
            cmpl_acked   <= 1'b0;
        end else if (!done_go) begin
            job_complete <= 1'b0;
            cmpl_acked   <= 1'b0;
        end else begin
            if (job_complete_ack) begin
                job_complete <= 1'b0;
                cmpl_acked   <= 1'b1;
            end else if (!cmpl_acked) begin
                job_complete <= 1'b1;
            end
        end
    end

    // Sequencer leaves DONE on the ack cycle itself
    assign complete_acked = job_complete && job_complete_ack;

endmodule

`default_nettype wire

// File: logic/quad_ctrl_pkg.sv
`default_nettype none

package quad_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Dimensions and latencies
    ////////////////////////////////////////////////////////////

    // Row or column index, half of a 1024 deep BRAM
    localparam int DIM_W            = 9;

    // Input rows held before the first output row
    localparam int PRIME_ROWS       = 4;

    // Sequence BRAM reads per output pixel
    localparam int SEQ_STEPS        = 5;
    localparam int SEQ_ADDR_W       = 3;
    localparam int SEQ_READ_LATENCY = 3;

    // 4 AWEs with 2 CEs each
    localparam int NUM_CE           = 8;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        PRIME,
        WAIT_FETCH,
        ACTIVE,
        FIN_ROW,
        DONE
    } ctrl_state_t;

    // Last valid indices, not counts
    typedef struct packed {
        logic [DIM_W-1:0] num_cols;
        logic [DIM_W-1:0] num_rows;
    } job_cfg_t;

    typedef struct packed {
        logic request;
        logic in_progress;
    } fetch_if_t;

    typedef struct packed {
        logic             ack;
        logic             complete;
        logic [DIM_W-1:0] full_count;
    } fetch_rsp_t;

endpackage

`default_nettype wire
